// ==== pipe5.f ====
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/fetch_stage.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_writeback.sv
verilog/pipe5_core.sv
tb/pipe5_checker.sv
tb/pipe5_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the pipe5 testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module pipe5_tb -f pipe5.f -o pipe5_sim \
  || { echo "Verilator build failed"; exit 1; }

# Keep running past assertion errors so the testbench can print its summary
sim_output=$(./obj_dir/pipe5_sim +verilator+error+limit+1000)
echo "$sim_output"

echo "$sim_output" | grep -qx "STATUS: PASS" && exit 0 || exit 1

// ==== tb/program_input.txt ====
// Section: test number, word count, program words, writeback count,
//          writeback pairs (register, value), final status (1 HALT, 2 illegal)

// 1 dependent ALU chain, forwarding from both registers
1 a
203F0005 20410003 40221800 44612000 48642800
4CA13000 50C33800 2107FFFF 44230800 00000000
9
01 5  02 8  03 d  04 8  05 8
06 d  07 1  08 0  01 fffffffffffffff8
1

// 2 store then load, load-use stalls on ra/rb and rb
2 9
203F0040 205F1234 B4410008 A4610008 40632000
B481FFF8 A4A1FFF8 20C50001 00000000
6
01 40  02 1234  03 1234  04 2468  05 2468  06 2469
1

// 3 not-taken BEQ, taken BEQ on r31, taken BEQ on forwarded zero
3 f
203F0001 E4200005 205F0002 207F0003 209F0004
E7E00003 20BF0005 20DF0006 20FF0007 205F0020
44212800 E4A00001 20DF0066 20FF0077 00000000
7
01 1  02 2  03 3  04 4  02 20  05 0  07 77
1

// 4 zero register writes dropped, reads give zero
4 8
23FF0055 203F0007 403FF800 4FE11000 53FF1800
A7FF0000 443F2000 00000000
4
01 7  02 7  03 1  04 7
1

// 5 undefined opcode stops the run
5 5
203F0011 20410022 FC000000 207F0001 00000000
2
01 11  02 33
2

// ==== tb/pipe5_tb.sv ====
/*
  Testbench for the pipe5 core
  Reads all test programs and their expected writebacks from
  tb/program_input.txt, models same-cycle instruction and data memories,
  runs each program from reset and checks every register writeback,
  the number of retired instructions and the final halt status.
  Run from the project root
*/
`timescale 1ns/1ps

module pipe5_tb;

  localparam int XLEN         = 64;
  localparam int NUM_TESTS    = 5;
  localparam int STIM_DEPTH   = 512;
  localparam int MEM_WORDS    = 256;
  localparam int HALF_PERIOD  = 50;    // 100 ns clock
  localparam int RESET_CYCLES = 10;

  logic                           CLOCK;
  logic                           RESET;
  logic [XLEN-1:0]                imem_addr;
  logic [isa_pkg::INST_WIDTH-1:0] imem_data;
  pipe_pkg::mem_cmd_t             dmem_command;
  logic [XLEN-1:0]                dmem_addr;
  logic [XLEN-1:0]                dmem_wdata;
  logic [XLEN-1:0]                dmem_rdata;
  logic                           wb_reg_wr_en;
  pipe_pkg::reg_idx_t             wb_reg_wr_idx;
  logic [XLEN-1:0]                wb_reg_wr_data;
  logic                           completed;
  pipe_pkg::halt_status_t         halt_status;

  logic [63:0]                    stim [STIM_DEPTH];      // Whole data file
  logic [isa_pkg::INST_WIDTH-1:0] imem [MEM_WORDS];
  logic [XLEN-1:0]                dmem [MEM_WORDS];
  int                             section_start [NUM_TESTS];
  int                             watchdog_cycles;        // 0 until budgeted
  int                             error_count;
  int                             failed_tests;
  string test_names [NUM_TESTS] = '{"alu_chain", "store_load", "branches",
                                    "zero_register", "halt_illegal"};
  // Instructions on the executed path, last one included
  int retire_counts [NUM_TESTS] = '{10, 9, 11, 8, 3};

  pipe5_core #(.XLEN(XLEN)) pipe5_core_inst (.*);

  bind pipe5_core pipe5_checker checker_inst (
    .CLOCK         (CLOCK),
    .RESET         (RESET),
    .dmem_command  (dmem_command),
    .wb_reg_wr_en  (wb_reg_wr_en),
    .wb_reg_wr_idx (wb_reg_wr_idx),
    .pc_low_bits   (imem_addr[1:0]),
    .completed     (completed),
    .halt_status   (halt_status)
  );

  initial
  begin
    CLOCK = 1'b0;
    forever #HALF_PERIOD CLOCK = ~CLOCK;
  end

  ////////////////////////////////////////
  // Memories, answered at the falling edge
  ////////////////////////////////////////
  initial
  begin
    imem_data  = isa_pkg::NOOP_INST;
    dmem_rdata = '0;
    forever
    begin
      @(negedge CLOCK);
      if (RESET)
      begin
        for (int i = 0; i < MEM_WORDS; i++)
          dmem[i] = 64'hd0d0_0000_0000_0000 + 64'(i * 8);   // Byte address in low bits
      end
      else if (dmem_command == pipe_pkg::MEM_STORE)
        dmem[dmem_addr[10:3]] = dmem_wdata;
      imem_data  = imem[imem_addr[9:2]];
      dmem_rdata = dmem[dmem_addr[10:3]];                   // Seen by a load this cycle
    end
  end

  // Program words plus 20 per test, four cycles each, plus reset
  task automatic index_sections();
    int pos;
    int n_words;
    int n_wb;
    int total;
    pos   = 0;
    total = 0;
    for (int t = 0; t < NUM_TESTS; t++)
    begin
      section_start[t] = pos;
      n_words = int'(stim[pos + 1]);
      n_wb    = int'(stim[pos + 2 + n_words]);
      total   = total + (n_words + 20) * 4 + RESET_CYCLES + 2;
      pos     = pos + 4 + n_words + 2 * n_wb;
    end
    watchdog_cycles = total;                // Starts the watchdog
  endtask

  task automatic check_writeback(input string name, input int k,
                                 input pipe_pkg::reg_idx_t exp_idx,
                                 input logic [XLEN-1:0] exp_value);
    assert (wb_reg_wr_idx == exp_idx && wb_reg_wr_data == exp_value)
    else
    begin
      $display("CHECK FAILED %s: writeback %0d expected r%0d = %h, actual r%0d = %h",
               name, k, exp_idx, exp_value, wb_reg_wr_idx, wb_reg_wr_data);
      error_count++;
    end
  endtask

  ////////////////////////////////////////
  // One test: load, reset, run to halt
  ////////////////////////////////////////
  task automatic run_test(input int t);
    int                     pos;
    int                     n_words;
    int                     n_wb;
    int                     wb_seen;
    int                     retired;
    int                     errors_before;
    int                     pair;
    bit                     done;
    pipe_pkg::halt_status_t exp_status;
    pos           = section_start[t];
    errors_before = error_count;
    n_words       = int'(stim[pos + 1]);
    n_wb          = int'(stim[pos + 2 + n_words]);
    exp_status    = pipe_pkg::halt_status_t'(stim[pos + 3 + n_words + 2 * n_wb][1:0]);
    assert (stim[pos] == 64'(t + 1))
    else
    begin
      $display("Data file section %0d is labelled as test %0d", t + 1, stim[pos]);
      error_count++;
    end

    @(negedge CLOCK);
    RESET = 1'b1;
    for (int i = 0; i < MEM_WORDS; i++)
      imem[i] = {isa_pkg::OP_NOOP, 26'(i * 4)};           // NOOPs tagged with address
    for (int i = 0; i < n_words; i++)
      imem[i] = stim[pos + 2 + i][31:0];
    repeat (RESET_CYCLES) @(negedge CLOCK);
    RESET = 1'b0;

    wb_seen = 0;
    retired = 0;
    done    = 1'b0;
    while (!done)
    begin
      @(negedge CLOCK);                     // Outputs settled since the rising edge
      if (completed)
        retired++;
      if (wb_reg_wr_en)
      begin
        if (wb_seen < n_wb)
        begin
          pair = pos + 3 + n_words + 2 * wb_seen;
          check_writeback(test_names[t], wb_seen, stim[pair][4:0], stim[pair + 1]);
        end
        wb_seen++;
      end
      if (completed && halt_status != pipe_pkg::NO_ERROR)
        done = 1'b1;
    end

    assert (halt_status == exp_status)
    else
    begin
      $display("CHECK FAILED %s: halt status expected %0d, actual %0d",
               test_names[t], exp_status, halt_status);
      error_count++;
    end
    assert (retired == retire_counts[t])
    else
    begin
      $display("CHECK FAILED %s: completed pulses expected %0d, actual %0d",
               test_names[t], retire_counts[t], retired);
      error_count++;
    end
    assert (wb_seen == n_wb)
    else
    begin
      $display("Test %s wrote back %0d registers where %0d were expected",
               test_names[t], wb_seen, n_wb);
      error_count++;
    end

    if (error_count != errors_before)
      failed_tests++;
    $display("Test %0d %s %s", t + 1, test_names[t],
             (error_count == errors_before) ? "passed" : "failed");
  endtask

  ////////////////////////////////////////
  // Main sequence and summary
  ////////////////////////////////////////
  initial
  begin
    bit file_ok;
    int checker_fails;
    RESET        = 1'b1;
    error_count  = 0;
    failed_tests = 0;
    $readmemh("tb/program_input.txt", stim);
    file_ok = !$isunknown(stim[0]);
    assert (file_ok)
    else
    begin
      $display("Could not read the test programs from tb/program_input.txt");
      error_count++;
    end
    if (file_ok)
    begin
      index_sections();
      for (int t = 0; t < NUM_TESTS; t++)
        run_test(t);
    end

    checker_fails = pipe5_core_inst.checker_inst.reset_fails
                  + pipe5_core_inst.checker_inst.zero_reg_fails
                  + pipe5_core_inst.checker_inst.align_fails
                  + pipe5_core_inst.checker_inst.status_fails;
    $display("Tests %0d, failed %0d, check errors %0d, assertion failures %0d",
             NUM_TESTS, failed_tests, error_count, checker_fails);
    if (error_count == 0 && checker_fails == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // Watchdog, armed once the data file is indexed
  initial
  begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge CLOCK);
    $display("Timeout: tests still running after %0d cycles", watchdog_cycles);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== tb/pipe5_checker.sv ====
/*
  Concurrent assertions on the pipe5 core outputs
  Bound into every pipe5_core instance by the testbench. Each assertion
  keeps its own failure count for the end-of-run summary
*/
`timescale 1ns/1ps

module pipe5_checker (
  input logic                   CLOCK,
  input logic                   RESET,
  input pipe_pkg::mem_cmd_t     dmem_command,
  input logic                   wb_reg_wr_en,
  input pipe_pkg::reg_idx_t     wb_reg_wr_idx,
  input logic [1:0]             pc_low_bits,    // imem_addr[1:0]
  input logic                   completed,
  input pipe_pkg::halt_status_t halt_status
);

  int reset_fails;      // One counter per assertion
  int zero_reg_fails;
  int align_fails;
  int status_fails;

  // Memory idle, no register write while reset is held
  reset_quiet: assert property (@(posedge CLOCK)
    RESET |-> (dmem_command == pipe_pkg::MEM_NONE && !wb_reg_wr_en))
  else
  begin
    $error("Memory command or register write active during reset");
    reset_fails++;
  end

  // r31 never reaches the write port
  no_zero_write: assert property (@(posedge CLOCK) disable iff (RESET)
    wb_reg_wr_en |-> wb_reg_wr_idx != pipe_pkg::ZERO_REG)
  else
  begin
    $error("Register write to the zero register");
    zero_reg_fails++;
  end

  pc_aligned: assert property (@(posedge CLOCK) disable iff (RESET)
    pc_low_bits == 2'b00)
  else
  begin
    $error("Instruction address not word aligned");
    align_fails++;
  end

  // Status only with a retiring instruction
  status_on_complete: assert property (@(posedge CLOCK) disable iff (RESET)
    !completed |-> halt_status == pipe_pkg::NO_ERROR)
  else
  begin
    $error("Halt status set without a completed instruction");
    status_fails++;
  end

endmodule

// ==== verilog/pipe5_core.sv ====
/*
  Top level of the pipe5 five-stage pipeline
  Wires fetch, decode with its register file, execute and the combined
  memory/writeback stage. Instruction and data memories sit outside and
  answer in the same cycle. XLEN is set here and passed down
*/
`timescale 1ns/1ps

module pipe5_core #(
  parameter int XLEN = 64
) (
  input  logic                           CLOCK,
  input  logic                           RESET,
  output logic [XLEN-1:0]                imem_addr,
  input  logic [isa_pkg::INST_WIDTH-1:0] imem_data,
  output pipe_pkg::mem_cmd_t             dmem_command,
  output logic [XLEN-1:0]                dmem_addr,
  output logic [XLEN-1:0]                dmem_wdata,
  input  logic [XLEN-1:0]                dmem_rdata,
  output logic                           wb_reg_wr_en,
  output pipe_pkg::reg_idx_t             wb_reg_wr_idx,
  output logic [XLEN-1:0]                wb_reg_wr_data,
  output logic                           completed,
  output pipe_pkg::halt_status_t         halt_status
);

  ////////////////////////////////////////
  // Stage-to-stage wires
  ////////////////////////////////////////
  logic [XLEN-1:0]                if_npc;
  logic [isa_pkg::INST_WIDTH-1:0] if_ir;
  logic                           if_valid;
  logic                           stall;          // Load-use, from decode
  logic                           take_branch;    // Redirect and squash
  logic [XLEN-1:0]                branch_target;
  pipe_pkg::reg_idx_t             rd_idx_a;
  pipe_pkg::reg_idx_t             rd_idx_b;
  logic [XLEN-1:0]                rd_data_a;
  logic [XLEN-1:0]                rd_data_b;

  // ID/EX
  logic [XLEN-1:0]                id_ex_npc;
  pipe_pkg::reg_idx_t             id_ex_ra_idx;
  pipe_pkg::reg_idx_t             id_ex_rb_idx;
  logic [XLEN-1:0]                id_ex_rega;
  logic [XLEN-1:0]                id_ex_regb;
  logic [XLEN-1:0]                id_ex_imm;
  pipe_pkg::reg_idx_t             id_ex_dest;
  isa_pkg::alu_func_t             id_ex_alu_func;
  logic                           id_ex_use_imm;
  logic                           id_ex_rd_mem;
  logic                           id_ex_wr_mem;
  logic                           id_ex_cond_branch;
  logic                           id_ex_halt;
  logic                           id_ex_illegal;
  logic                           id_ex_valid;

  // EX/MEM
  logic [XLEN-1:0]                ex_mem_rega;
  logic [XLEN-1:0]                ex_mem_alu_result;
  logic                           ex_mem_rd_mem;
  logic                           ex_mem_wr_mem;
  pipe_pkg::reg_idx_t             ex_mem_dest;
  logic                           ex_mem_halt;
  logic                           ex_mem_illegal;
  logic                           ex_mem_valid;

  // MEM/WB back to EX for forwarding
  pipe_pkg::reg_idx_t             mem_wb_dest;
  logic                           mem_wb_valid;
  logic [XLEN-1:0]                mem_wb_result;

  ////////////////////////////////////////
  // Stages
  ////////////////////////////////////////
  fetch_stage #(.XLEN(XLEN)) fetch_stage_inst (.*);

  decode_stage #(.XLEN(XLEN)) decode_stage_inst (
    .squash (take_branch),
    .*
  );

  register_file #(.XLEN(XLEN)) register_file_inst (
    .wr_en   (wb_reg_wr_en),     // Write port from writeback
    .wr_idx  (wb_reg_wr_idx),
    .wr_data (wb_reg_wr_data),
    .*
  );

  execute_stage #(.XLEN(XLEN)) execute_stage_inst (.*);

  memory_writeback #(.XLEN(XLEN)) memory_writeback_inst (.*);

endmodule

// ==== verilog/memory_writeback.sv ====
/*
  MEM and WB stages of pipe5
  Drives the data memory from EX/MEM, fills MEM/WB with load data or
  the ALU result, and presents the register write port and halt status
*/
`timescale 1ns/1ps

module memory_writeback #(
  parameter int XLEN = 64
) (
  input  logic                  CLOCK,
  input  logic                  RESET,
  input  logic [XLEN-1:0]       ex_mem_rega,
  input  logic [XLEN-1:0]       ex_mem_alu_result,
  input  logic                  ex_mem_rd_mem,
  input  logic                  ex_mem_wr_mem,
  input  pipe_pkg::reg_idx_t    ex_mem_dest,
  input  logic                  ex_mem_halt,
  input  logic                  ex_mem_illegal,
  input  logic                  ex_mem_valid,
  input  logic [XLEN-1:0]       dmem_rdata,
  output pipe_pkg::mem_cmd_t    dmem_command,
  output logic [XLEN-1:0]       dmem_addr,
  output logic [XLEN-1:0]       dmem_wdata,
  output pipe_pkg::reg_idx_t    mem_wb_dest,
  output logic                  mem_wb_valid,
  output logic [XLEN-1:0]       mem_wb_result,
  output logic                  wb_reg_wr_en,
  output pipe_pkg::reg_idx_t    wb_reg_wr_idx,
  output logic [XLEN-1:0]       wb_reg_wr_data,
  output logic                  completed,
  output pipe_pkg::halt_status_t halt_status
);

  logic mem_wb_store;
  logic mem_wb_halt;
  logic mem_wb_illegal;

  // Bubbles carry no memory flags
  assign dmem_command = ex_mem_rd_mem ? pipe_pkg::MEM_LOAD  :
                        ex_mem_wr_mem ? pipe_pkg::MEM_STORE : pipe_pkg::MEM_NONE;
  assign dmem_addr    = ex_mem_alu_result;
  assign dmem_wdata   = ex_mem_rega;

  ////////////////////////////////////////
  // MEM/WB register
  ////////////////////////////////////////
  always_ff @(posedge CLOCK or posedge RESET)
  begin
    if (RESET)
    begin
      mem_wb_valid   <= 1'b0;
      mem_wb_dest    <= pipe_pkg::ZERO_REG;
      mem_wb_store   <= 1'b0;
      mem_wb_halt    <= 1'b0;
      mem_wb_illegal <= 1'b0;
    end
    else
    begin
      mem_wb_valid   <= ex_mem_valid;
      mem_wb_dest    <= ex_mem_dest;
      mem_wb_store   <= ex_mem_wr_mem;
      mem_wb_halt    <= ex_mem_halt;
      mem_wb_illegal <= ex_mem_illegal;
    end
  end

  always_ff @(posedge CLOCK)
    mem_wb_result <= ex_mem_rd_mem ? dmem_rdata : ex_mem_alu_result;

  // Writeback straight from MEM/WB
  assign wb_reg_wr_en   = mem_wb_valid && !mem_wb_store && mem_wb_dest != pipe_pkg::ZERO_REG;
  assign wb_reg_wr_idx  = mem_wb_dest;
  assign wb_reg_wr_data = mem_wb_result;
  assign completed      = mem_wb_valid;    // One pulse per retired instruction
  assign halt_status    = mem_wb_illegal ? pipe_pkg::HALTED_ON_ILLEGAL :
                          mem_wb_halt    ? pipe_pkg::HALTED_ON_HALT    : pipe_pkg::NO_ERROR;

endmodule

// ==== verilog/execute_stage.sv ====
/*
  EX stage of pipe5
  Operand forwarding from EX/MEM and MEM/WB, the ALU and BEQ resolution.
  The EX/MEM register carries take_branch, with the target in the ALU
  result; while it is set the next EX/MEM entry is a bubble
*/
`timescale 1ns/1ps

module execute_stage #(
  parameter int XLEN = 64
) (
  input  logic               CLOCK,
  input  logic               RESET,
  input  logic [XLEN-1:0]    id_ex_npc,
  input  pipe_pkg::reg_idx_t id_ex_ra_idx,
  input  pipe_pkg::reg_idx_t id_ex_rb_idx,
  input  logic [XLEN-1:0]    id_ex_rega,
  input  logic [XLEN-1:0]    id_ex_regb,
  input  logic [XLEN-1:0]    id_ex_imm,
  input  pipe_pkg::reg_idx_t id_ex_dest,
  input  isa_pkg::alu_func_t id_ex_alu_func,
  input  logic               id_ex_use_imm,
  input  logic               id_ex_rd_mem,
  input  logic               id_ex_wr_mem,
  input  logic               id_ex_cond_branch,
  input  logic               id_ex_halt,
  input  logic               id_ex_illegal,
  input  logic               id_ex_valid,
  input  pipe_pkg::reg_idx_t mem_wb_dest,
  input  logic               mem_wb_valid,
  input  logic [XLEN-1:0]    mem_wb_result,
  output logic               take_branch,
  output logic [XLEN-1:0]    branch_target,
  output logic [XLEN-1:0]    ex_mem_rega,
  output logic [XLEN-1:0]    ex_mem_alu_result,
  output logic               ex_mem_rd_mem,
  output logic               ex_mem_wr_mem,
  output pipe_pkg::reg_idx_t ex_mem_dest,
  output logic               ex_mem_halt,
  output logic               ex_mem_illegal,
  output logic               ex_mem_valid
);

  logic [XLEN-1:0] opa;        // Forwarded ra
  logic [XLEN-1:0] opb;        // Forwarded rb
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  logic [XLEN-1:0] alu_out;
  logic            br_taken;
  logic [XLEN-1:0] br_target;

  // Youngest producer wins; loads in EX/MEM are covered by the stall
  function automatic logic [XLEN-1:0] fwd_value(input pipe_pkg::reg_idx_t src,
                                                input logic [XLEN-1:0] reg_value);
    if (src == pipe_pkg::ZERO_REG)
      return reg_value;                    // r31 is never forwarded
    if (ex_mem_valid && !ex_mem_rd_mem && ex_mem_dest == src)
      return ex_mem_alu_result;
    if (mem_wb_valid && mem_wb_dest == src)
      return mem_wb_result;
    return reg_value;
  endfunction

  always_comb
  begin
    opa   = fwd_value(id_ex_ra_idx, id_ex_rega);
    opb   = fwd_value(id_ex_rb_idx, id_ex_regb);
    alu_a = id_ex_use_imm ? opb : opa;     // Memory forms: rb + imm
    alu_b = id_ex_use_imm ? id_ex_imm : opb;
    case (id_ex_alu_func)
      isa_pkg::ALU_SUB:   alu_out = alu_a - alu_b;
      isa_pkg::ALU_AND:   alu_out = alu_a & alu_b;
      isa_pkg::ALU_OR:    alu_out = alu_a | alu_b;
      isa_pkg::ALU_CMPEQ: alu_out = XLEN'(alu_a == alu_b);
      default:            alu_out = alu_a + alu_b;
    endcase
  end

  // BEQ tests the forwarded ra
  assign br_taken      = id_ex_cond_branch && opa == '0;
  assign br_target     = id_ex_npc + (id_ex_imm << 2);
  assign branch_target = ex_mem_alu_result;

  ////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////
  always_ff @(posedge CLOCK or posedge RESET)
  begin
    if (RESET)
    begin
      take_branch    <= 1'b0;
      ex_mem_valid   <= 1'b0;
      ex_mem_dest    <= pipe_pkg::ZERO_REG;
      ex_mem_rd_mem  <= 1'b0;
      ex_mem_wr_mem  <= 1'b0;
      ex_mem_halt    <= 1'b0;
      ex_mem_illegal <= 1'b0;
    end
    else
    begin
      take_branch    <= !take_branch && br_taken;   // Squash the wrong-path entry
      ex_mem_valid   <= !take_branch && id_ex_valid;
      ex_mem_dest    <= take_branch ? pipe_pkg::ZERO_REG : id_ex_dest;
      ex_mem_rd_mem  <= !take_branch && id_ex_rd_mem;
      ex_mem_wr_mem  <= !take_branch && id_ex_wr_mem;
      ex_mem_halt    <= !take_branch && id_ex_halt;
      ex_mem_illegal <= !take_branch && id_ex_illegal;
    end
  end

  always_ff @(posedge CLOCK)
  begin
    ex_mem_rega       <= opa;              // Store data
    ex_mem_alu_result <= br_taken ? br_target : alu_out;
  end

endmodule

// ==== verilog/decode_stage.sv ====
/*
  ID stage of pipe5
  Decodes the IF/ID word, reads the register file and fills ID/EX.
  Raises stall when the load sitting in ID/EX feeds this instruction;
  ID/EX then takes a bubble, as it does on a branch squash
*/
`timescale 1ns/1ps

module decode_stage #(
  parameter int XLEN = 64
) (
  input  logic                           CLOCK,
  input  logic                           RESET,
  input  logic [XLEN-1:0]                if_npc,
  input  logic [isa_pkg::INST_WIDTH-1:0] if_ir,
  input  logic                           if_valid,
  input  logic                           squash,
  input  logic [XLEN-1:0]                rd_data_a,
  input  logic [XLEN-1:0]                rd_data_b,
  output pipe_pkg::reg_idx_t             rd_idx_a,
  output pipe_pkg::reg_idx_t             rd_idx_b,
  output logic                           stall,
  output logic [XLEN-1:0]                id_ex_npc,
  output pipe_pkg::reg_idx_t             id_ex_ra_idx,
  output pipe_pkg::reg_idx_t             id_ex_rb_idx,
  output logic [XLEN-1:0]                id_ex_rega,
  output logic [XLEN-1:0]                id_ex_regb,
  output logic [XLEN-1:0]                id_ex_imm,
  output pipe_pkg::reg_idx_t             id_ex_dest,
  output isa_pkg::alu_func_t             id_ex_alu_func,
  output logic                           id_ex_use_imm,
  output logic                           id_ex_rd_mem,
  output logic                           id_ex_wr_mem,
  output logic                           id_ex_cond_branch,
  output logic                           id_ex_halt,
  output logic                           id_ex_illegal,
  output logic                           id_ex_valid
);

  isa_pkg::op_t       opcode;
  pipe_pkg::reg_idx_t ra;
  pipe_pkg::reg_idx_t rb;
  pipe_pkg::reg_idx_t rc;
  logic [XLEN-1:0]    imm;
  pipe_pkg::reg_idx_t dest;
  isa_pkg::alu_func_t alu_func;
  logic               alu_op;      // Register-register ALU form
  logic               use_ra;
  logic               use_rb;
  logic               use_imm;
  logic               rd_mem;
  logic               wr_mem;
  logic               cond_branch;
  logic               halt;
  logic               illegal;
  logic               bubble;

  // Fields
  assign opcode   = isa_pkg::op_t'(if_ir[isa_pkg::INST_WIDTH-1 -: 6]);
  assign ra       = if_ir[isa_pkg::RA_LSB +: 5];
  assign rb       = if_ir[isa_pkg::RB_LSB +: 5];
  assign rc       = if_ir[isa_pkg::RC_LSB +: 5];
  assign imm      = {{(XLEN-isa_pkg::IMM_WIDTH){if_ir[isa_pkg::IMM_WIDTH-1]}},
                     if_ir[isa_pkg::IMM_WIDTH-1:0]};
  assign rd_idx_a = ra;
  assign rd_idx_b = rb;

  always_comb
  begin
    dest        = pipe_pkg::ZERO_REG;      // No write unless set below
    alu_func    = isa_pkg::ALU_ADD;        // Address adds use ADD
    alu_op      = 1'b0;
    use_ra      = 1'b0;
    use_rb      = 1'b0;
    use_imm     = 1'b0;
    rd_mem      = 1'b0;
    wr_mem      = 1'b0;
    cond_branch = 1'b0;
    halt        = 1'b0;
    illegal     = 1'b0;
    if (if_valid)
    begin
      case (opcode)
        isa_pkg::OP_ADD:   alu_op = 1'b1;
        isa_pkg::OP_SUB:   {alu_op, alu_func} = {1'b1, isa_pkg::ALU_SUB};
        isa_pkg::OP_AND:   {alu_op, alu_func} = {1'b1, isa_pkg::ALU_AND};
        isa_pkg::OP_OR:    {alu_op, alu_func} = {1'b1, isa_pkg::ALU_OR};
        isa_pkg::OP_CMPEQ: {alu_op, alu_func} = {1'b1, isa_pkg::ALU_CMPEQ};
        isa_pkg::OP_LDA, isa_pkg::OP_LDQ:
        begin
          dest    = ra;
          use_rb  = 1'b1;
          use_imm = 1'b1;
          rd_mem  = (opcode == isa_pkg::OP_LDQ);
        end
        isa_pkg::OP_STQ:
        begin
          {use_ra, use_rb, use_imm} = 3'b111;    // ra is the store data
          wr_mem  = 1'b1;
        end
        isa_pkg::OP_BEQ:   {use_ra, cond_branch} = 2'b11;
        isa_pkg::OP_HALT:  halt = 1'b1;
        isa_pkg::OP_NOOP:  ;
        default:           illegal = 1'b1;
      endcase
      if (alu_op)
        {dest, use_ra, use_rb} = {rc, 2'b11};
    end
  end

  // Load-use hazard against own ID/EX entry
  assign stall  = id_ex_valid && id_ex_rd_mem && id_ex_dest != pipe_pkg::ZERO_REG &&
                  ((use_ra && ra == id_ex_dest) || (use_rb && rb == id_ex_dest));
  assign bubble = stall || squash;

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////
  always_ff @(posedge CLOCK or posedge RESET)
  begin
    if (RESET)
    begin
      id_ex_valid       <= 1'b0;
      id_ex_dest        <= pipe_pkg::ZERO_REG;
      id_ex_rd_mem      <= 1'b0;
      id_ex_wr_mem      <= 1'b0;
      id_ex_cond_branch <= 1'b0;
      id_ex_halt        <= 1'b0;
      id_ex_illegal     <= 1'b0;
    end
    else
    begin
      id_ex_valid       <= !bubble && if_valid;
      id_ex_dest        <= bubble ? pipe_pkg::ZERO_REG : dest;
      id_ex_rd_mem      <= !bubble && rd_mem;
      id_ex_wr_mem      <= !bubble && wr_mem;
      id_ex_cond_branch <= !bubble && cond_branch;
      id_ex_halt        <= !bubble && halt;
      id_ex_illegal     <= !bubble && illegal;
    end
  end

  // Operands and immediates, meaningless in a bubble
  always_ff @(posedge CLOCK)
  begin
    id_ex_npc      <= if_npc;
    id_ex_ra_idx   <= ra;
    id_ex_rb_idx   <= rb;
    id_ex_rega     <= rd_data_a;
    id_ex_regb     <= rd_data_b;
    id_ex_imm      <= imm;
    id_ex_alu_func <= alu_func;
    id_ex_use_imm  <= use_imm;
  end

endmodule

// ==== verilog/register_file.sv ====
/*
  32-entry integer register file beside the decoder
  Two combinational read ports and one write port from writeback.
  A read of the register being written sees the new value
*/
`timescale 1ns/1ps

module register_file #(
  parameter int XLEN = 64
) (
  input  logic               CLOCK,
  input  logic               RESET,
  input  pipe_pkg::reg_idx_t rd_idx_a,
  input  pipe_pkg::reg_idx_t rd_idx_b,
  input  logic               wr_en,
  input  pipe_pkg::reg_idx_t wr_idx,
  input  logic [XLEN-1:0]    wr_data,
  output logic [XLEN-1:0]    rd_data_a,
  output logic [XLEN-1:0]    rd_data_b
);

  logic [XLEN-1:0] regs [32];

  // Zero register first, then write-through, then storage
  function automatic logic [XLEN-1:0] read_port(input pipe_pkg::reg_idx_t idx);
    if (idx == pipe_pkg::ZERO_REG)
      return '0;
    if (wr_en && wr_idx == idx)
      return wr_data;
    return regs[idx];
  endfunction

  always_comb
  begin
    rd_data_a = read_port(rd_idx_a);
    rd_data_b = read_port(rd_idx_b);
  end

  always_ff @(posedge CLOCK or posedge RESET)
  begin
    if (RESET)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (wr_en && wr_idx != pipe_pkg::ZERO_REG)   // r31 writes dropped
      regs[wr_idx] <= wr_data;
  end

endmodule

// ==== verilog/fetch_stage.sv ====
/*
  IF stage of pipe5
  Program counter, instruction fetch and the IF/ID register.
  PC steps by 4, holds on a load-use stall and loads the target
  of a branch taken from EX/MEM. Instruction memory answers same cycle
*/
`timescale 1ns/1ps

module fetch_stage #(
  parameter int XLEN = 64
) (
  input  logic                           CLOCK,
  input  logic                           RESET,
  input  logic                           stall,          // Load-use hold from decode
  input  logic                           take_branch,    // Redirect from EX/MEM
  input  logic [XLEN-1:0]                branch_target,
  input  logic [isa_pkg::INST_WIDTH-1:0] imem_data,
  output logic [XLEN-1:0]                imem_addr,
  output logic [XLEN-1:0]                if_npc,
  output logic [isa_pkg::INST_WIDTH-1:0] if_ir,
  output logic                           if_valid
);

  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] next_pc;

  assign imem_addr = pc;                   // Fetch address every cycle
  assign next_pc   = pc + XLEN'(4);

  ////////////////////////////////////////
  // PC and IF/ID register
  ////////////////////////////////////////
  always_ff @(posedge CLOCK or posedge RESET)
  begin
    if (RESET)
    begin
      pc       <= '0;
      if_npc   <= '0;
      if_ir    <= isa_pkg::NOOP_INST;
      if_valid <= 1'b0;
    end
    else if (take_branch)
    begin
      pc       <= branch_target;           // Wrong-path fetch dropped
      if_ir    <= isa_pkg::NOOP_INST;
      if_valid <= 1'b0;
    end
    else if (!stall)
    begin
      pc       <= next_pc;
      if_npc   <= next_pc;
      if_ir    <= imem_data;
      if_valid <= 1'b1;
    end
    // Stall without branch: everything holds
  end

endmodule

// ==== verilog/pipe_pkg.sv ====
/*
  Pipeline-level types for pipe5
  Register index, data-memory commands and the halt status reported
  at writeback. Used by scoped name from the stages and the top level
*/
package pipe_pkg;

  typedef logic [4:0] reg_idx_t;

  localparam reg_idx_t ZERO_REG = 5'd31;  // Reads zero, writes dropped

  // Data-memory command, driven from MEM
  typedef enum logic [1:0] {
    MEM_NONE  = 2'd0,
    MEM_LOAD  = 2'd1,
    MEM_STORE = 2'd2
  } mem_cmd_t;

  typedef enum logic [1:0] {
    NO_ERROR          = 2'd0,
    HALTED_ON_HALT    = 2'd1,
    HALTED_ON_ILLEGAL = 2'd2
  } halt_status_t;

endpackage

// ==== verilog/isa_pkg.sv ====
/*
  Instruction set of the pipe5 core
  Opcodes, field positions, ALU functions and the NOOP word.
  Decode and execute refer to these by scoped name, e.g. isa_pkg::OP_ADD
*/
package isa_pkg;

  localparam int INST_WIDTH = 32;  // Every instruction is one word
  localparam int RA_LSB     = 21;  // ra in [25:21]
  localparam int RB_LSB     = 16;  // rb in [20:16]
  localparam int RC_LSB     = 11;  // rc in [15:11], ALU forms only
  localparam int IMM_WIDTH  = 16;  // Displacement in [15:0], sign-extended

  // Opcode in bits 31 to 26
  typedef enum logic [5:0] {
    OP_HALT  = 6'h00,  // All-zero word stops the machine
    OP_NOOP  = 6'h01,
    OP_LDA   = 6'h08,  // ra = rb + imm
    OP_ADD   = 6'h10,  // rc = ra op rb
    OP_SUB   = 6'h11,
    OP_AND   = 6'h12,
    OP_OR    = 6'h13,
    OP_CMPEQ = 6'h14,  // rc = (ra == rb)
    OP_LDQ   = 6'h29,  // ra = mem[rb + imm]
    OP_STQ   = 6'h2d,  // mem[rb + imm] = ra
    OP_BEQ   = 6'h39   // Branch to NPC + 4*imm when ra is zero
  } op_t;

  typedef enum logic [2:0] {
    ALU_ADD   = 3'd0,
    ALU_SUB   = 3'd1,
    ALU_AND   = 3'd2,
    ALU_OR    = 3'd3,
    ALU_CMPEQ = 3'd4
  } alu_func_t;

  // Bubble word held by an empty IF/ID register
  localparam logic [INST_WIDTH-1:0] NOOP_INST = {OP_NOOP, 26'h0};

endpackage
